// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
LOG=sim.log

# the rom and the model load the program by its bare file name
cp verif/prog.hex prog.hex
if [ $? -ne 0 ]; then
  echo "could not copy the program file"
  exit 1
fi

verilator --binary --assert -f rv_soc.f --top-module tb_rv_soc_top -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed" "$LOG"; then
  exit 0
fi
exit 1

// File: rv_soc.f
src/rv_pkg.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_data_ram.sv
src/rv_core_pipelined.sv
src/rv_soc_top.sv
verif/tb_rv_soc_top.sv

// File: src/rv_alu.sv
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
  input  alu_op_e         i_op,
  input  logic [XLEN-1:0] i_a,
  input  logic [XLEN-1:0] i_b,
  output logic [XLEN-1:0] o_result,
  output logic            o_equal
);

  logic lt_signed;

  assign lt_signed = $signed(i_a) < $signed(i_b);

  always_comb begin
    case (i_op)
      ALU_ADD:    o_result = i_a + i_b;
      ALU_SUB:    o_result = i_a - i_b;
      ALU_AND:    o_result = i_a & i_b;
      ALU_OR:     o_result = i_a | i_b;
      ALU_XOR:    o_result = i_a ^ i_b;
      ALU_SLT:    o_result = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_PASS_B: o_result = i_b;
      default:    o_result = '0;
    endcase
  end

  assign o_equal = (i_a == i_b);                 // beq / bne compare

endmodule

// File: src/rv_core_pipelined.sv
`timescale 1ns/1ps

module rv_core_pipelined import rv_pkg::*; (
  input  logic            clk,
  input  logic            i_rst_n,
  input  logic [XLEN-1:0] i_dmem_rdata,
  output logic [XLEN-1:0] o_dmem_addr,
  output logic [XLEN-1:0] o_dmem_wdata,
  output logic [3:0]      o_dmem_we,
  output logic            o_dmem_re,
  output logic            o_wb_valid,
  output logic            o_wb_we,
  output logic [XLEN-1:0] o_wb_pc,
  output logic [XLEN-1:0] o_wb_data,
  output logic [4:0]      o_wb_rd
);

  // ex stage
  logic [XLEN-1:0] ex_pc, ex_imm, ex_target;
  logic [31:0]     ex_inst;
  logic            ex_valid, ex_take;
  logic [4:0]      ex_rs1, ex_rs2, ex_rd;
  alu_op_e         ex_alu_op;
  wb_sel_e         ex_wb_sel;
  logic            ex_use_imm, ex_reg_we, ex_mem_re, ex_mem_we;
  logic            ex_branch, ex_branch_ne, ex_jump, ex_equal;
  logic [XLEN-1:0] rf_rs1_data, rf_rs2_data;
  logic [XLEN-1:0] ex_a, ex_rs2_val, ex_b, ex_alu_out;
  logic            fwd_ok;

  // ex/wb register
  logic [XLEN-1:0] wb_alu_q, wb_pc4_q;
  wb_sel_e         wb_sel_q;

  rv_fetch u_fetch (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_redirect (ex_take),
    .i_target   (ex_target),
    .o_pc       (ex_pc),
    .o_inst     (ex_inst),
    .o_valid    (ex_valid)
  );

  rv_decode u_decode (
    .i_inst      (ex_inst),
    .o_rs1       (ex_rs1),
    .o_rs2       (ex_rs2),
    .o_rd        (ex_rd),
    .o_imm       (ex_imm),
    .o_alu_op    (ex_alu_op),
    .o_use_imm   (ex_use_imm),
    .o_reg_we    (ex_reg_we),
    .o_mem_re    (ex_mem_re),
    .o_mem_we    (ex_mem_we),
    .o_branch    (ex_branch),
    .o_branch_ne (ex_branch_ne),
    .o_jump      (ex_jump),
    .o_wb_sel    (ex_wb_sel)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .i_rs1      (ex_rs1),
    .i_rs2      (ex_rs2),
    .i_rd       (o_wb_rd),
    .i_we       (o_wb_we),
    .i_wdata    (o_wb_data),
    .o_rs1_data (rf_rs1_data),
    .o_rs2_data (rf_rs2_data)
  );

  // single wb -> ex forward, covers load-use as ram data lands in wb
  assign fwd_ok     = o_wb_valid && o_wb_we && (o_wb_rd != 5'd0);
  assign ex_a       = (fwd_ok && (o_wb_rd == ex_rs1)) ? o_wb_data : rf_rs1_data;
  assign ex_rs2_val = (fwd_ok && (o_wb_rd == ex_rs2)) ? o_wb_data : rf_rs2_data;
  assign ex_b       = ex_use_imm ? ex_imm : ex_rs2_val;

  rv_alu u_alu (
    .i_op     (ex_alu_op),
    .i_a      (ex_a),
    .i_b      (ex_b),
    .o_result (ex_alu_out),
    .o_equal  (ex_equal)
  );

  assign ex_take   = ex_valid && (ex_jump || (ex_branch && (ex_equal ^ ex_branch_ne)));
  assign ex_target = ex_pc + ex_imm;             // branch and jal are pc relative

  assign o_dmem_addr  = ex_alu_out;
  assign o_dmem_wdata = ex_rs2_val;
  assign o_dmem_we    = (ex_valid && ex_mem_we) ? 4'hf : 4'h0;   // sw writes all lanes
  assign o_dmem_re    = ex_valid && ex_mem_re;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_wb_valid <= 1'b0;
      o_wb_we    <= 1'b0;
    end else begin
      o_wb_valid <= ex_valid;
      o_wb_we    <= ex_valid && ex_reg_we;
    end
  end

  always_ff @(posedge clk) begin
    o_wb_pc  <= ex_pc;
    o_wb_rd  <= ex_rd;
    wb_sel_q <= ex_wb_sel;
    wb_alu_q <= ex_alu_out;
    wb_pc4_q <= ex_pc + 32'd4;
  end

  always_comb begin
    case (wb_sel_q)
      WB_MEM:  o_wb_data = i_dmem_rdata;
      WB_PC4:  o_wb_data = wb_pc4_q;
      default: o_wb_data = wb_alu_q;
    endcase
  end

endmodule

// File: src/rv_data_ram.sv
`timescale 1ns/1ps

module rv_data_ram import rv_pkg::*; (
  input  logic            clk,
  input  logic [3:0]      i_we_a,
  input  logic [XLEN-1:0] i_addr_a,
  input  logic [XLEN-1:0] i_wdata_a,
  output logic [XLEN-1:0] o_rdata_a,
  input  logic [XLEN-1:0] i_addr_b,
  output logic [XLEN-1:0] o_rdata_b
);

  logic [XLEN-1:0]    mem [0:DMEM_DEPTH-1];
  logic [DMEM_AW-1:0] word_a, word_b;

  assign word_a = i_addr_a[DMEM_AW+1:2];         // word addressed
  assign word_b = i_addr_b[DMEM_AW+1:2];

  initial begin
    for (int i = 0; i < DMEM_DEPTH; i++) mem[i] = '0;
  end

  always_ff @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (i_we_a[b]) mem[word_a][8*b +: 8] <= i_wdata_a[8*b +: 8];
    end
    o_rdata_a <= mem[word_a];                    // read-first
  end

  // debug port, read only
  always_ff @(posedge clk) begin
    o_rdata_b <= mem[word_b];
  end

endmodule

// File: src/rv_decode.sv
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
  input  logic [31:0]     i_inst,
  output logic [4:0]      o_rs1,
  output logic [4:0]      o_rs2,
  output logic [4:0]      o_rd,
  output logic [XLEN-1:0] o_imm,
  output alu_op_e         o_alu_op,
  output logic            o_use_imm,
  output logic            o_reg_we,
  output logic            o_mem_re,
  output logic            o_mem_we,
  output logic            o_branch,
  output logic            o_branch_ne,
  output logic            o_jump,
  output wb_sel_e         o_wb_sel
);

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign o_rs1  = i_inst[19:15];
  assign o_rs2  = i_inst[24:20];
  assign o_rd   = i_inst[11:7];

  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {i_inst[31:12], 12'b0};
  assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    o_imm       = imm_i;
    o_alu_op    = ALU_ADD;
    o_use_imm   = 1'b0;
    o_reg_we    = 1'b0;                          // anything unmatched is a no-op
    o_mem_re    = 1'b0;
    o_mem_we    = 1'b0;
    o_branch    = 1'b0;
    o_branch_ne = 1'b0;
    o_jump      = 1'b0;
    o_wb_sel    = WB_ALU;
    case (opcode)
      OPC_OP: begin
        o_reg_we = 1'b1;
        case (funct3)
          3'b000:  o_alu_op = i_inst[30] ? ALU_SUB : ALU_ADD;
          3'b111:  o_alu_op = ALU_AND;
          3'b110:  o_alu_op = ALU_OR;
          3'b100:  o_alu_op = ALU_XOR;
          3'b010:  o_alu_op = ALU_SLT;
          default: o_reg_we = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        o_use_imm = 1'b1;
        o_reg_we  = 1'b1;
        case (funct3)
          3'b000:  o_alu_op = ALU_ADD;
          3'b111:  o_alu_op = ALU_AND;
          3'b110:  o_alu_op = ALU_OR;
          3'b100:  o_alu_op = ALU_XOR;
          default: o_reg_we = 1'b0;
        endcase
      end
      OPC_LUI: begin
        o_imm     = imm_u;
        o_alu_op  = ALU_PASS_B;
        o_use_imm = 1'b1;
        o_reg_we  = 1'b1;
      end
      OPC_LOAD: begin
        o_use_imm = 1'b1;                        // address = rs1 + imm
        o_reg_we  = (funct3 == 3'b010);          // lw only
        o_mem_re  = (funct3 == 3'b010);
        o_wb_sel  = WB_MEM;
      end
      OPC_STORE: begin
        o_imm     = imm_s;
        o_use_imm = 1'b1;
        o_mem_we  = (funct3 == 3'b010);          // sw only
      end
      OPC_BRANCH: begin
        o_imm       = imm_b;
        o_alu_op    = ALU_SUB;
        o_branch    = (funct3 == 3'b000) || (funct3 == 3'b001);
        o_branch_ne = (funct3 == 3'b001);
      end
      OPC_JAL: begin
        o_imm    = imm_j;
        o_reg_we = 1'b1;
        o_jump   = 1'b1;
        o_wb_sel = WB_PC4;                       // link value
      end
      default: ;
    endcase
  end

endmodule

// File: src/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch import rv_pkg::*; (
  input  logic            clk,
  input  logic            i_rst_n,
  input  logic            i_redirect,
  input  logic [XLEN-1:0] i_target,
  output logic [XLEN-1:0] o_pc,
  output logic [31:0]     o_inst,
  output logic            o_valid
);

  logic [31:0]     rom [0:IMEM_DEPTH-1];
  logic [XLEN-1:0] pc_q;                         // address being fetched this cycle

  initial $readmemh(IMEM_FILE, rom);

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      pc_q    <= '0;
      o_valid <= 1'b0;
    end else begin
      pc_q    <= i_redirect ? i_target : pc_q + 32'd4;
      o_valid <= !i_redirect;                    // redirect kills the slot now in IF
    end
  end

  // if/ex pair, payload only
  always_ff @(posedge clk) begin
    o_pc   <= pc_q;
    o_inst <= rom[pc_q[IMEM_AW+1:2]];
  end

endmodule

// File: src/rv_pkg.sv
package rv_pkg;

  localparam int XLEN       = 32;
  localparam int IMEM_DEPTH = 256;               // instruction rom words
  localparam int DMEM_DEPTH = 256;               // data ram words
  localparam int IMEM_AW    = $clog2(IMEM_DEPTH);
  localparam int DMEM_AW    = $clog2(DMEM_DEPTH);

  localparam string IMEM_FILE = "prog.hex";      // shared with the testbench model

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B                                   // lui passes the immediate
  } alu_op_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC4
  } wb_sel_e;

endpackage

// File: src/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
  input  logic            clk,
  input  logic [4:0]      i_rs1,
  input  logic [4:0]      i_rs2,
  input  logic [4:0]      i_rd,
  input  logic            i_we,
  input  logic [XLEN-1:0] i_wdata,
  output logic [XLEN-1:0] o_rs1_data,
  output logic [XLEN-1:0] o_rs2_data
);

  logic [XLEN-1:0] regs [1:31];                  // x0 has no storage

  always_ff @(posedge clk) begin
    if (i_we && (i_rd != 5'd0)) begin
      regs[i_rd] <= i_wdata;
    end
  end

  // no write-through here, the core forwards from wb
  assign o_rs1_data = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

// File: src/rv_soc_top.sv
`timescale 1ns/1ps

module rv_soc_top import rv_pkg::*; (
  input  logic            clk,
  input  logic            i_rst_n,
  input  logic [XLEN-1:0] i_dbg_addr,
  output logic [XLEN-1:0] o_dbg_rdata,
  output logic            o_wb_valid,
  output logic            o_wb_we,
  output logic [XLEN-1:0] o_wb_pc,
  output logic [XLEN-1:0] o_wb_data,
  output logic [4:0]      o_wb_rd
);

  logic [XLEN-1:0] dmem_addr, dmem_wdata, dmem_rdata;
  logic [3:0]      dmem_we;

  rv_core_pipelined u_core (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_dmem_rdata (dmem_rdata),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_wdata (dmem_wdata),
    .o_dmem_we    (dmem_we),
    .o_dmem_re    (),                            // ram port a reads every cycle
    .o_wb_valid   (o_wb_valid),
    .o_wb_we      (o_wb_we),
    .o_wb_pc      (o_wb_pc),
    .o_wb_data    (o_wb_data),
    .o_wb_rd      (o_wb_rd)
  );

  rv_data_ram u_dmem (
    .clk       (clk),
    .i_we_a    (dmem_we),
    .i_addr_a  (dmem_addr),
    .i_wdata_a (dmem_wdata),
    .o_rdata_a (dmem_rdata),
    .i_addr_b  (i_dbg_addr),                     // port b is the debug read port
    .o_rdata_b (o_dbg_rdata)
  );

endmodule

// File: verif/prog.hex
// one instruction word per line, addresses from 0x00 in steps of 4
// word  // assembly
00500093  // 00 addi x1, x0, 5
00700113  // 04 addi x2, x0, 7
402081B3  // 08 sub  x3, x1, x2
0011A233  // 0c slt  x4, x3, x1
0551C293  // 10 xori x5, x3, 0x55
0FF2F313  // 14 andi x6, x5, 0xff
123453B7  // 18 lui  x7, 0x12345
0063E433  // 1c or   x8, x7, x6
005474B3  // 20 and  x9, x8, x5
0090E013  // 24 ori  x0, x1, 9
00400533  // 28 add  x10, x0, x4
00802823  // 2c sw   x8, 16(x0)
01002583  // 30 lw   x11, 16(x0)
00A58633  // 34 add  x12, x11, x10
00A20463  // 38 beq  x4, x10, +8
00100693  // 3c addi x13, x0, 1
00209463  // 40 bne  x1, x2, +8
00200693  // 44 addi x13, x0, 2
00A21463  // 48 bne  x4, x10, +8
00208463  // 4c beq  x1, x2, +8
0080076F  // 50 jal  x14, +8
00300693  // 54 addi x13, x0, 3
00C747B3  // 58 xor  x15, x14, x12
00F02A23  // 5c sw   x15, 20(x0)
0000006F  // 60 jal  x0, 0

// File: verif/tb_rv_soc_top.sv
`timescale 1ns/1ps

module tb_rv_soc_top import rv_pkg::*; ();

  localparam int HALT_TIMEOUT = 2000;            // cycles
  localparam int MODEL_STEPS  = 1000;

  logic            clk;
  logic            i_rst_n;
  logic [XLEN-1:0] i_dbg_addr;
  logic [XLEN-1:0] o_dbg_rdata;
  logic            o_wb_valid;
  logic            o_wb_we;
  logic [XLEN-1:0] o_wb_pc;
  logic [XLEN-1:0] o_wb_data;
  logic [4:0]      o_wb_rd;

  // instruction set model state
  logic [31:0]     prog [0:IMEM_DEPTH-1];
  logic [XLEN-1:0] xreg [0:31];
  logic [XLEN-1:0] model_mem [0:DMEM_DEPTH-1];
  logic [XLEN-1:0] exp_pc[$];
  logic [XLEN-1:0] exp_data[$];
  logic [XLEN-1:0] store_addr[$];
  logic [4:0]      exp_rd[$];
  logic            exp_we[$];
  logic [XLEN-1:0] halt_pc;
  logic            model_halted = 1'b0;
  logic            halt_seen = 1'b0;

  int ret_idx = 0;
  int test_errors = 0;
  int test_checks = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int total_checks = 0;

  rv_soc_top dut (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_dbg_addr  (i_dbg_addr),
    .o_dbg_rdata (o_dbg_rdata),
    .o_wb_valid  (o_wb_valid),
    .o_wb_we     (o_wb_we),
    .o_wb_pc     (o_wb_pc),
    .o_wb_data   (o_wb_data),
    .o_wb_rd     (o_wb_rd)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    test_checks++;
    assert (actual === expected) else begin
      $display("** Error: %s = 0x%08h, expected 0x%08h", name, actual, expected);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      tests_passed++;
      $display("PASS  %s, %0d checks", name, test_checks);
    end else begin
      tests_failed++;
      $display("FAIL  %s, %0d errors in %0d checks", name, test_errors, test_checks);
    end
    total_checks += test_checks;
    test_errors = 0;
    test_checks = 0;
  endtask

  // architectural step through the program with one entry per retirement
  task automatic run_model();
    logic [31:0]     inst;
    logic [XLEN-1:0] pc, next_pc, a, b, res, addr;
    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_j;
    logic            we;
    int              steps;
    pc    = '0;
    steps = 0;
    for (int i = 0; i < 32; i++)
      xreg[i] = '0;
    for (int i = 0; i < DMEM_DEPTH; i++)
      model_mem[i] = '0;
    $readmemh(IMEM_FILE, prog);
    while (!model_halted && steps < MODEL_STEPS) begin
      inst    = prog[pc[IMEM_AW+1:2]];
      a       = xreg[inst[19:15]];
      b       = xreg[inst[24:20]];
      imm_i   = {{20{inst[31]}}, inst[31:20]};
      imm_s   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      imm_b   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      imm_j   = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      res     = '0;
      we      = 1'b1;
      next_pc = pc + 32'd4;
      case (opcode_e'(inst[6:0]))
        OPC_OP: begin
          case (inst[14:12])
            3'b000:  res = inst[30] ? a - b : a + b;
            3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  res = a ^ b;
            3'b110:  res = a | b;
            3'b111:  res = a & b;
            default: we = 1'b0;
          endcase
        end
        OPC_OP_IMM: begin
          case (inst[14:12])
            3'b000:  res = a + imm_i;
            3'b100:  res = a ^ imm_i;
            3'b110:  res = a | imm_i;
            3'b111:  res = a & imm_i;
            default: we = 1'b0;
          endcase
        end
        OPC_LUI:  res = {inst[31:12], 12'b0};
        OPC_LOAD: begin
          addr = a + imm_i;
          res  = model_mem[addr[DMEM_AW+1:2]];
        end
        OPC_STORE: begin
          we   = 1'b0;
          addr = a + imm_s;
          model_mem[addr[DMEM_AW+1:2]] = b;
          store_addr.push_back(addr);
        end
        OPC_BRANCH: begin
          we = 1'b0;
          if ((a == b) != inst[12])              // funct3 bit 0 picks bne
            next_pc = pc + imm_b;
        end
        OPC_JAL: begin
          res     = pc + 32'd4;
          next_pc = pc + imm_j;
          if (imm_j == '0) begin                 // jump to itself ends the program
            model_halted = 1'b1;
            halt_pc      = pc;
          end
        end
        default: we = 1'b0;
      endcase
      exp_pc.push_back(pc);
      exp_rd.push_back(inst[11:7]);
      exp_we.push_back(we);
      exp_data.push_back(res);
      if (we && inst[11:7] != 5'd0)
        xreg[inst[11:7]] = res;
      pc = next_pc;
      steps++;
    end
  endtask

  // compares the current retirement with the next model entry
  task automatic check_retire();
    if (i_rst_n && o_wb_valid) begin
      if (ret_idx < exp_pc.size()) begin
        check_value("o_wb_pc", o_wb_pc, exp_pc[ret_idx]);
        check_value("o_wb_we", {31'b0, o_wb_we}, {31'b0, exp_we[ret_idx]});
        if (exp_we[ret_idx]) begin
          check_value("o_wb_rd", {27'b0, o_wb_rd}, {27'b0, exp_rd[ret_idx]});
          check_value("o_wb_data", o_wb_data, exp_data[ret_idx]);
        end
        ret_idx++;
      end else begin
        assert (o_wb_pc === halt_pc) else begin
          $display("instruction at pc 0x%08h retired after the halting jal", o_wb_pc);
          test_errors++;
        end
      end
      if (o_wb_pc === halt_pc)
        halt_seen = 1'b1;
    end
  endtask

  initial begin
    i_rst_n    = 1'b0;
    i_dbg_addr = '0;
    run_model();
    if (!model_halted) begin
      $display("model found no halting jal within %0d steps", MODEL_STEPS);
      test_errors++;
    end
    finish_test("reference model");

    repeat (5) begin
      @(negedge clk);
      check_value("o_wb_valid", {31'b0, o_wb_valid}, 32'd0);
    end
    i_rst_n = 1'b1;
    @(negedge clk);
    check_value("o_wb_valid", {31'b0, o_wb_valid}, 32'd0);   // pipeline still empty
    finish_test("reset state");

    for (int c = 0; c < HALT_TIMEOUT && !halt_seen; c++) begin
      @(negedge clk);                            // outputs settled since the rising edge
      check_retire();
    end
    if (!halt_seen) begin
      $display("timeout, the halting jal did not retire within %0d cycles", HALT_TIMEOUT);
      test_errors++;
    end
    finish_test("retire stream");

    foreach (store_addr[i]) begin
      i_dbg_addr = store_addr[i];
      @(negedge clk);                            // port b data one cycle later
      check_retire();
      check_value("o_dbg_rdata", o_dbg_rdata, model_mem[store_addr[i][DMEM_AW+1:2]]);
    end
    finish_test("memory image");

    $display("summary: %0d passed, %0d failed, %0d checks",
             tests_passed, tests_failed, total_checks);
    if (tests_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
